/* dv/ethTxOut_patterns.txt */
# port linkUp payloadLength expectedFcs(hex) payloadBytes(hex)...
# fcs is the final crc-32 value, sent least significant byte first
0 1 9 CBF43926 31 32 33 34 35 36 37 38 39
1 1 3 352441C2 61 62 63
1 1 1 E8B7BE43 61
0 1 14 20159D7F 6d 65 73 73 61 67 65 20 64 69 67 65 73 74
0 0 11 0D4A1185 68 65 6c 6c 6f 20 77 6f 72 6c 64
1 1 26 4C2750BD 61 62 63 64 65 66 67 68 69 6a 6b 6c 6d 6e 6f 70 71 72 73 74 75 76 77 78 79 7a
0 1 3 352441C2 61 62 63

/* ethTxOut.f */
design/ethTxPkg.sv
design/frameScheduler.sv
design/ethCrc32.sv
design/txFramer.sv
design/ethTxOut.sv
dv/clockGen.sv
dv/ethTxOut_assertions.sv
dv/ethTxOut_tb.sv

/* Bender.yml */
package:
  name: ethTxOut

sources:
  - design/ethTxPkg.sv
  - design/frameScheduler.sv
  - design/ethCrc32.sv
  - design/txFramer.sv
  - design/ethTxOut.sv
  - target: test
    files:
      - dv/clockGen.sv
      - dv/ethTxOut_assertions.sv
      - dv/ethTxOut_tb.sv

/* dv/ethTxOut_tb.sv */
`timescale 1ns/10ps

module ethTxOut_tb;

	import ethTxPkg::*;

	logic Clk;
	logic reset;
	logic LinkUp;
	byteStream_t [numPorts-1:0] srcIn;
	logic [numPorts-1:0] ReqIn;
	logic [numPorts-1:0] ReqConfirm;
	logic TxEn;
	logic [3:0] TxData;

	// one entry per record, payload bytes kept flat
	int recPort[$];
	int recLink[$];
	int recLen[$];
	int recOffset[$];
	logic [31:0] recFcs[$];
	logic [7:0] payload[$];

	int seed = 86;
	int lastWinner;

	clockGen clockGen_inst (.Clk(Clk));

	ethTxOut ethTxOut_inst
	(
		.Clk        (Clk),
		.reset      (reset),
		.LinkUp     (LinkUp),
		.srcIn      (srcIn),
		.ReqIn      (ReqIn),
		.ReqConfirm (ReqConfirm),
		.TxEn       (TxEn),
		.TxData     (TxData)
	);

	task automatic stopRun(input string reason);
		$display("%s", reason);
		$display("test failed");
		$fatal(1, "stopping at the first error");
	endtask

	// ----------------------------------------
	// stimulus file
	// ----------------------------------------

	task automatic readRecords();
		int fd;
		int code;
		int port;
		int link;
		int len;
		logic [31:0] fcs;
		logic [7:0] b;
		string line;
		fd = $fopen("dv/ethTxOut_patterns.txt", "r");
		if (fd == 0)
			stopRun("cannot open dv/ethTxOut_patterns.txt");
		// skip the two column lines
		code = $fgets(line, fd);
		code = $fgets(line, fd);
		while ($fscanf(fd, "%d %d %d %h", port, link, len, fcs) == 4)
		begin
			recPort.push_back(port);
			recLink.push_back(link);
			recLen.push_back(len);
			recFcs.push_back(fcs);
			recOffset.push_back(payload.size());
			repeat (len)
			begin
				code = $fscanf(fd, "%h", b);
				assert (code == 1)
				else
					stopRun("pattern file ends inside a record");
				payload.push_back(b);
			end
		end
		$fclose(fd);
		assert (recPort.size() > 0)
		else
			stopRun("pattern file holds no records");
	endtask

	// preamble, SFD, payload, then FCS lsb first
	function automatic logic [7:0] expectedByte(input int r, input int i);
		if (i < preambleLen)
			return preambleByte;
		else if (i == preambleLen)
			return sfdByte;
		else if (i < preambleLen + 1 + recLen[r])
			return payload[recOffset[r] + i - preambleLen - 1];
		else
			return 8'(recFcs[r] >> (8 * (i - preambleLen - 1 - recLen[r])));
	endfunction

	// ----------------------------------------
	// source driver and line monitor
	// ----------------------------------------

	task automatic expectQuiet(input int cycles, input string when);
		repeat (cycles)
		begin
			@(negedge Clk);
			assert ((ReqConfirm == '0) && !TxEn)
			else
				stopRun($sformatf("[FAIL] %0t: ReqConfirm or TxEn high %s", $time, when));
		end
	endtask

	task automatic sendFrame(input int r, input int idleCycles);
		int p;
		int k;
		int waited;
		byteStream_t b;
		p = recPort[r];
		// drop the link early so its registered copy is low at the request
		if (recLink[r] == 0)
		begin
			@(posedge Clk);
			LinkUp <= 1'b0;
		end
		repeat (idleCycles) @(posedge Clk);
		@(posedge Clk);
		ReqIn[p] <= 1'b1;
		if (recLink[r] == 0)
		begin
			expectQuiet(30, "while LinkUp is low");
			@(posedge Clk);
			LinkUp <= 1'b1;
		end
		waited = 0;
		@(negedge Clk);
		while (!ReqConfirm[p])
		begin
			waited++;
			if (waited > 400)
				stopRun($sformatf("no ReqConfirm for port %0d within 400 cycles", p));
			@(negedge Clk);
		end
		@(posedge Clk);
		ReqIn[p] <= 1'b0;
		// one byte every second cycle
		for (k = 0; k < recLen[r]; k++)
		begin
			b.val = 1'b1;
			b.sof = (k == 0);
			b.eof = (k == recLen[r] - 1);
			b.data = payload[recOffset[r] + k];
			srcIn[p] <= b;
			@(posedge Clk);
			srcIn[p] <= '0;
			@(posedge Clk);
		end
	endtask

	task automatic checkFrame(input int r);
		int waited;
		int cycles;
		int burst;
		logic [3:0] lowNibble;
		logic [7:0] got;
		burst = 2 * (preambleLen + 1 + recLen[r] + fcsLen);
		waited = 0;
		@(negedge Clk);
		while (!TxEn)
		begin
			waited++;
			if (waited > 400)
				stopRun($sformatf("TxEn did not rise within 400 cycles for record %0d", r));
			@(negedge Clk);
		end
		cycles = 0;
		while (TxEn && (cycles < burst + 2))
		begin
			if (cycles % 2 == 0)
				lowNibble = TxData;
			else
			begin
				got = {TxData, lowNibble};
				assert (got == expectedByte(r, cycles / 2))
				else
					stopRun($sformatf("[FAIL] %0t: record %0d byte %0d is %h, expected %h",
						$time, r, cycles / 2, got, expectedByte(r, cycles / 2)));
			end
			cycles++;
			@(negedge Clk);
		end
		assert (cycles == burst)
		else
			stopRun($sformatf("[FAIL] %0t: record %0d burst lasted %0d cycles, expected %0d",
				$time, r, cycles, burst));
	endtask

	always @(negedge Clk)
	begin
		if (ethTxOut_inst.protocolChecks.failCount != 0)
			stopRun("a bound protocol assertion on the DUT failed");
	end

	// ----------------------------------------
	// main sequence
	// ----------------------------------------

	initial
	begin
		int i;
		int idle;
		int first;
		int second;
		bit pair;
		reset = 1'b1;
		LinkUp = 1'b1;
		ReqIn = '0;
		srcIn = '0;
		lastWinner = 1;
		readRecords();
		repeat (5) @(posedge Clk);
		reset <= 1'b0;
		expectQuiet(8, "before any request");
		i = 0;
		while (i < recPort.size())
		begin
			pair = 1'b0;
			if ((i + 1 < recPort.size()) && (recPort[i] != recPort[i + 1]) &&
				(recLink[i] != 0) && (recLink[i + 1] != 0))
				pair = (i == 0) || ($random(seed) & 1);
			idle = $unsigned($random(seed)) % 5;
			if (pair)
			begin
				// tie goes to the port not granted last time
				first = (recPort[i] == 1 - lastWinner) ? i : i + 1;
				second = (first == i) ? i + 1 : i;
				fork
					sendFrame(i, idle);
					sendFrame(i + 1, idle);
					begin
						checkFrame(first);
						checkFrame(second);
					end
				join
				lastWinner = recPort[second];
				i += 2;
			end
			else
			begin
				fork
					sendFrame(i, idle);
					checkFrame(i);
				join
				lastWinner = recPort[i];
				i++;
			end
		end
		if (ethTxOut_inst.protocolChecks.failCount == 0)
		begin
			$display("test passed");
			$finish;
		end
		else
			stopRun("a bound protocol assertion on the DUT failed");
	end

endmodule

/* dv/ethTxOut_assertions.sv */
`timescale 1ns/10ps

module ethTxOut_assertions
(
	input logic Clk,
	input logic reset,
	input logic LinkUp,
	input logic [ethTxPkg::numPorts-1:0] ReqConfirm,
	input logic TxEn
);

	// failures so far, watched by the testbench
	int failCount = 0;

	// ----------------------------------------
	// reset and grant rules
	// ----------------------------------------

	txEnQuietInReset: assert property (@(posedge Clk) reset && $past(reset) |-> !TxEn)
	else
	begin
		failCount++;
		$error("TxEn high while reset is asserted");
	end

	singleGrant: assert property (@(posedge Clk) disable iff (reset) $onehot0(ReqConfirm))
	else
	begin
		failCount++;
		$error("ReqConfirm has both bits set");
	end

	// registered LinkUp gates the grant, so two low cycles rule it out
	noGrantLinkDown: assert property (@(posedge Clk) disable iff (reset)
		!$past(LinkUp, 1) && !$past(LinkUp, 2) |-> ReqConfirm == '0)
	else
	begin
		failCount++;
		$error("ReqConfirm high while LinkUp was low");
	end

	grantIsPulse: assert property (@(posedge Clk) disable iff (reset)
		|ReqConfirm |=> (ReqConfirm & $past(ReqConfirm)) == '0)
	else
	begin
		failCount++;
		$error("ReqConfirm held longer than one cycle");
	end

endmodule

bind ethTxOut ethTxOut_assertions protocolChecks (.*);

/* dv/clockGen.sv */
`timescale 1ns/10ps

module clockGen
(
	output logic Clk
);

	// 100 ns period, starts low
	initial
	begin
		Clk = 1'b0;
		forever
			#50 Clk = ~Clk;
	end

endmodule

/* design/ethTxOut.sv */
`timescale 1ns/10ps

module ethTxOut
(
	input logic Clk,
	input logic reset,
	input logic LinkUp,
	input ethTxPkg::byteStream_t [ethTxPkg::numPorts-1:0] srcIn,
	input logic [ethTxPkg::numPorts-1:0] ReqIn,
	output logic [ethTxPkg::numPorts-1:0] ReqConfirm,
	output logic TxEn,
	output logic [3:0] TxData
);

	import ethTxPkg::*;

	byteStream_t schedOut;
	byteStream_t crcOut;
	logic [31:0] fcsValue;
	logic fcsReady;
	logic lineBusy;

	// ----------------------------------------
	// scheduler, crc, framer
	// ----------------------------------------

	frameScheduler frameScheduler_inst
	(
		.Clk        (Clk),
		.reset      (reset),
		.LinkUp     (LinkUp),
		.srcIn      (srcIn),
		.ReqIn      (ReqIn),
		.lineBusy   (lineBusy),
		.ReqConfirm (ReqConfirm),
		.schedOut   (schedOut)
	);

	ethCrc32 ethCrc32_inst
	(
		.Clk       (Clk),
		.reset     (reset),
		.streamIn  (schedOut),
		.streamOut (crcOut),
		.fcsValue  (fcsValue),
		.fcsReady  (fcsReady)
	);

	txFramer txFramer_inst
	(
		.Clk      (Clk),
		.reset    (reset),
		.frameIn  (crcOut),
		.fcsValue (fcsValue),
		.fcsReady (fcsReady),
		.lineBusy (lineBusy),
		.TxEn     (TxEn),
		.TxData   (TxData)
	);

endmodule

/* design/txFramer.sv */
`timescale 1ns/10ps

module txFramer
(
	input logic Clk,
	input logic reset,
	input ethTxPkg::byteStream_t frameIn,
	input logic [31:0] fcsValue,
	input logic fcsReady,
	output logic lineBusy,
	output logic TxEn,
	output logic [3:0] TxData
);

	import ethTxPkg::*;

	framerState_e state;

	// index 0 takes new bytes, the head is at lineDepth-1
	logic [lineDepth-1:0][7:0] dataLine;
	logic [lineDepth-1:0] eofLine;
	logic [31:0] fcsHold;
	logic [cntWidth-1:0] byteCnt;
	logic phase;
	logic sofIn;
	logic sending;
	logic [7:0] headByte;

	assign sofIn = frameIn.val && frameIn.sof;

	// busy already in the sof cycle so no grant slips in
	assign lineBusy = (state != framerIdle) || sofIn;

	assign sending = (state == framerPreamble) || (state == framerPayload) ||
		(state == framerFcs);

	// fcs bytes go out lsb first from the shifting hold register
	assign headByte = (state == framerFcs) ? fcsHold[7:0] : dataLine[lineDepth-1];

	// ----------------------------------------
	// delay line and fcs hold
	// ----------------------------------------

	always_ff @(posedge Clk)
	begin
		if ((state == framerIdle) && sofIn)
		begin
			dataLine[0] <= frameIn.data;
			dataLine[1] <= sfdByte;
			for (int i = 2; i < lineDepth; i++)
				dataLine[i] <= preambleByte;
		end
		else if (phase)
			dataLine <= {dataLine[lineDepth-2:0], frameIn.data};

		if (fcsReady)
			fcsHold <= fcsValue;
		else if ((state == framerFcs) && phase)
			fcsHold <= fcsHold >> 8;
	end

	// ----------------------------------------
	// framing FSM and nibble output
	// ----------------------------------------

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			state <= framerIdle;
			phase <= 1'b0;
			byteCnt <= '0;
			eofLine <= '0;
			TxEn <= 1'b0;
			TxData <= '0;
		end
		else
		begin
			// phase 0 sends the low nibble, phase 1 the high one and shifts
			phase <= ~phase;
			TxEn <= sending;
			if (sending)
				TxData <= phase ? headByte[7:4] : headByte[3:0];
			else
				TxData <= '0;

			if ((state == framerIdle) && sofIn)
				eofLine <= {{(lineDepth-1){1'b0}}, frameIn.eof};
			else if (phase)
				eofLine <= {eofLine[lineDepth-2:0], frameIn.val && frameIn.eof};

			case (state)
				framerIdle:
				begin
					if (sofIn)
					begin
						// line is loaded, first low nibble next cycle
						phase <= 1'b0;
						byteCnt <= '0;
						state <= framerPreamble;
					end
				end

				framerPreamble:
				begin
					// seven preamble bytes and the SFD
					if (phase && (byteCnt == cntWidth'(preambleLen)))
					begin
						byteCnt <= '0;
						state <= framerPayload;
					end
					else if (phase)
						byteCnt <= byteCnt + 1'b1;
				end

				framerPayload:
				begin
					if (phase && eofLine[lineDepth-1])
					begin
						byteCnt <= '0;
						state <= framerFcs;
					end
				end

				framerFcs:
				begin
					if (phase && (byteCnt == cntWidth'(fcsLen - 1)))
					begin
						byteCnt <= '0;
						state <= framerGap;
					end
					else if (phase)
						byteCnt <= byteCnt + 1'b1;
				end

				framerGap:
				begin
					if (phase && (byteCnt == cntWidth'(ifgBytes - 1)))
					begin
						byteCnt <= '0;
						state <= framerIdle;
					end
					else if (phase)
						byteCnt <= byteCnt + 1'b1;
				end

				default:
					state <= framerIdle;
			endcase
		end
	end

endmodule

/* design/ethCrc32.sv */
`timescale 1ns/10ps

module ethCrc32
(
	input logic Clk,
	input logic reset,
	input ethTxPkg::byteStream_t streamIn,
	output ethTxPkg::byteStream_t streamOut,
	output logic [31:0] fcsValue,
	output logic fcsReady
);

	import ethTxPkg::*;

	logic [31:0] crcReg;

	// fold one byte into the running crc, lsb first
	function automatic logic [31:0] crcByte(input logic [31:0] crcIn, input logic [7:0] dataIn);
		logic [31:0] c;
		c = crcIn ^ {24'h0, dataIn};
		for (int i = 0; i < 8; i++)
		begin
			if (c[0])
				c = (c >> 1) ^ crcPoly;
			else
				c = c >> 1;
		end
		return c;
	endfunction

	// ----------------------------------------
	// running crc and stream delay
	// ----------------------------------------

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			crcReg <= crcResidue;
			streamOut <= '0;
			fcsReady <= 1'b0;
		end
		else
		begin
			streamOut <= streamIn;

			// sof restarts from the seed value
			if (streamIn.val && streamIn.sof)
				crcReg <= crcByte(crcResidue, streamIn.data);
			else if (streamIn.val)
				crcReg <= crcByte(crcReg, streamIn.data);

			// crcReg is final while the eof byte sits on streamOut
			fcsReady <= streamOut.val && streamOut.eof;
		end
	end

	// held until the next frame ends, so a new frame may start early
	always_ff @(posedge Clk)
	begin
		if (streamOut.val && streamOut.eof)
			fcsValue <= crcReg ^ crcResidue;
	end

endmodule

/* design/frameScheduler.sv */
`timescale 1ns/10ps

module frameScheduler
(
	input logic Clk,
	input logic reset,
	input logic LinkUp,
	input ethTxPkg::byteStream_t [ethTxPkg::numPorts-1:0] srcIn,
	input logic [ethTxPkg::numPorts-1:0] ReqIn,
	input logic lineBusy,
	output logic [ethTxPkg::numPorts-1:0] ReqConfirm,
	output ethTxPkg::byteStream_t schedOut
);

	import ethTxPkg::*;

	schedState_e state;

	logic linkUpReg;
	logic lastWinner;
	logic grantPort;
	logic pickPort;
	logic schedFree;
	byteStream_t selected;

	// ----------------------------------------
	// arbitration
	// ----------------------------------------

	// new grants only between frames and with the link up
	// a one-byte frame still in schedOut has not reached the framer yet
	assign schedFree = (state == schedIdle) && linkUpReg && !lineBusy && !schedOut.val;

	// port not granted last time has priority on a tie
	always_comb
	begin
		if (ReqIn[~lastWinner])
			pickPort = ~lastWinner;
		else
			pickPort = lastWinner;
	end

	assign selected = srcIn[grantPort];

	// ----------------------------------------
	// state machine and forwarding register
	// ----------------------------------------

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			state <= schedIdle;
			linkUpReg <= 1'b0;
			// port 1 counts as last winner so port 0 goes first
			lastWinner <= 1'b1;
			grantPort <= 1'b0;
			ReqConfirm <= '0;
			schedOut <= '0;
		end
		else
		begin
			linkUpReg <= LinkUp;
			ReqConfirm <= '0;

			// granted port passes through one register
			if (state != schedIdle)
				schedOut <= selected;
			else
				schedOut <= '0;

			case (state)
				schedIdle:
				begin
					if (schedFree && (|ReqIn))
					begin
						ReqConfirm[pickPort] <= 1'b1;
						grantPort <= pickPort;
						lastWinner <= pickPort;
						state <= schedGranted;
					end
				end

				schedGranted:
				begin
					// waiting for the first byte of the frame
					if (selected.val && selected.eof)
						state <= schedIdle;
					else if (selected.val)
						state <= schedForwarding;
				end

				schedForwarding:
				begin
					if (selected.val && selected.eof)
						state <= schedIdle;
				end

				default:
					state <= schedIdle;
			endcase
		end
	end

endmodule

/* design/ethTxPkg.sv */
package ethTxPkg;

	// ----------------------------------------
	// frame format
	// ----------------------------------------

	// number of local byte sources
	localparam int numPorts = 2;

	localparam logic [7:0] preambleByte = 8'h55;
	localparam logic [7:0] sfdByte = 8'hD5;

	// preamble bytes ahead of the SFD
	localparam int preambleLen = 7;
	localparam int fcsLen = 4;

	// inter-frame gap in byte times
	localparam int ifgBytes = 12;

	// framer delay line, payload head plus SFD plus preamble
	localparam int lineDepth = preambleLen + 2;

	// wide enough for the longest framer count (the gap)
	localparam int cntWidth = $clog2(ifgBytes);

	// ----------------------------------------
	// crc-32, reflected form
	// ----------------------------------------

	localparam logic [31:0] crcPoly = 32'hEDB88320;
	localparam logic [31:0] crcResidue = 32'hFFFFFFFF;

	// one byte of a source stream with its framing flags
	typedef struct packed {
		logic val;
		logic sof;
		logic eof;
		logic [7:0] data;
	} byteStream_t;

	typedef enum logic [1:0] {
		schedIdle,
		schedGranted,
		schedForwarding
	} schedState_e;

	typedef enum logic [2:0] {
		framerIdle,
		framerPreamble,
		framerPayload,
		framerFcs,
		framerGap
	} framerState_e;

endpackage
